// ==== build.f ====
hdl/csr_pkg.sv
hdl/csr_wb_adapter.sv
hdl/perf_event_sampler.sv
hdl/cs_registers.sv
hdl/csr_subsystem_top.sv
dv/csr_assertions.sv
dv/csr_tb.sv

// ==== dv/csr_tb.sv ====
// seeded random test of the CSR subsystem; counter model assumes no bus access to counters while counting
`timescale 1ns/1ns
`default_nettype none

module csr_tb
  import csr_pkg::*;
();

  logic                    clk;
  logic                    rst_n;
  wb_req_t                 wb_req;
  wb_rsp_t                 wb_rsp;
  logic [4:0]              core_id;
  logic [4:0]              cluster_id;
  core_events_t            core_events;
  logic [N_EXT_EVENTS-1:0] ext_events;
  logic [31:0]             curr_pc_if;
  logic [31:0]             curr_pc_id;
  logic                    save_pc_if;
  logic                    save_pc_id;
  logic [31:0]             epcr;

  integer seed;

  // reference model
  logic [31:0]                m_scratch;
  logic [31:0]                m_epc;
  logic [N_PERF_COUNTERS-1:0] m_pcer;
  logic [1:0]                 m_pcmr;
  logic [31:0]                m_cnt [N_PERF_COUNTERS];
  logic                       m_count_en;  // model counts only in the event test
  logic                       m_stall_q;
  perf_events_t               m_ev;

  csr_subsystem_top csr_subsystem_top_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .wb_req_i      (wb_req),
    .wb_rsp_o      (wb_rsp),
    .core_id_i     (core_id),
    .cluster_id_i  (cluster_id),
    .core_events_i (core_events),
    .ext_events_i  (ext_events),
    .curr_pc_if_i  (curr_pc_if),
    .curr_pc_id_i  (curr_pc_id),
    .save_pc_if_i  (save_pc_if),
    .save_pc_id_i  (save_pc_id),
    .epcr_o        (epcr)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  ////////////////////////////////////////////////////////////
  // model rules
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] op_result(input csr_op_e op, input logic [31:0] old_v,
                                            input logic [31:0] d);
    case (op)
      CSR_OP_WRITE: return d;
      CSR_OP_SET:   return old_v | d;
      CSR_OP_CLEAR: return old_v & ~d;
      default:      return old_v;
    endcase
  endfunction

  // what each counter sees this cycle
  function automatic perf_events_t qualify_events(input core_events_t ce,
                                                  input logic [N_EXT_EVENTS-1:0] ext,
                                                  input logic stall_q);
    perf_events_t ev;
    ev              = '0;
    ev[EV_CYCLES]   = 1'b1;
    ev[EV_INSTR]    = !ce.stall_id;
    ev[EV_IMISS]    = ce.instr_fetch;
    ev[EV_LOAD]     = ce.mem_load;
    ev[EV_STORE]    = ce.mem_store;
    ev[EV_LD_STALL] = ce.ld_stall && !stall_q;  // masked by last cycle's stall
    ev[EV_JR_STALL] = ce.jr_stall && !stall_q;
    ev[EV_JUMP]     = ce.jump && !stall_q;
    ev[EV_BRANCH]   = ce.branch && !stall_q;
    for (int i = 0; i < N_EXT_EVENTS; i++)
      ev[EV_EXT_BASE + i] = ext[i];
    return ev;
  endfunction

  function automatic logic is_mapped(input logic [11:0] a);
    return (a == CSR_MCPUID) || (a == CSR_MIMPID) || (a == CSR_MHARTID) ||
           (a == CSR_MSCRATCH) || (a == CSR_MEPC) || (a == CSR_PCER) ||
           (a == CSR_PCMR) || (a[11:5] == CSR_PCCR_BASE[11:5]);
  endfunction

  function automatic wb_rsp_t acked(input logic [31:0] v);
    return {1'b1, v};
  endfunction

  task automatic model_write(input csr_op_e op, input logic [11:0] addr, input logic [31:0] d);
    logic [31:0] v;
    if (addr[11:10] != 2'b11)  // read-only space ignores writes
    begin
      case (addr)
        CSR_MSCRATCH: m_scratch = op_result(op, m_scratch, d);
        CSR_MEPC:     m_epc     = op_result(op, m_epc, d);
        CSR_PCER:
        begin
          v      = op_result(op, 32'(m_pcer), d);
          m_pcer = v[N_PERF_COUNTERS-1:0];
        end
        CSR_PCMR:
        begin
          v      = op_result(op, 32'(m_pcmr), d);
          m_pcmr = v[1:0];
        end
        default: ;
      endcase
    end
  endtask

  // one edge per cycle, decision taken on the inputs held over that cycle
  always @(posedge clk)
  begin
    m_ev = qualify_events(core_events, ext_events, m_stall_q);
    if (m_count_en)
    begin
      for (int i = 0; i < N_PERF_COUNTERS; i++)
        if (m_ev[i] && m_pcer[i] && m_pcmr[0])
          m_cnt[i] <= m_cnt[i] + 32'd1;
    end
    m_stall_q <= core_events.stall_id;
  end

  ////////////////////////////////////////////////////////////
  // checks and bus driver
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string name);
    if (got !== exp)
      abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic check_rsp(input wb_rsp_t got, input wb_rsp_t exp, input string name);
    if (got !== exp)
      abort_run($sformatf("** Error: %s ack=%h dat=%h, expected ack=%h dat=%h",
                          name, got.ack, got.dat, exp.ack, exp.dat));
  endtask

  task automatic expect_ack_low();
    if (wb_rsp.ack)
      abort_run("extra acknowledge seen after the bus cycle ended");
  endtask

  task automatic bus_start(input logic we, input csr_op_e op, input logic [11:0] addr,
                           input logic [31:0] d);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = {(we ? op : CSR_OP_NONE), addr};  // op rides in adr[13:12]
    wb_req.dat = d;
  endtask

  // idle_gap keeps cyc up with stb low for that many extra cycles
  task automatic bus_finish(input int idle_gap, output wb_rsp_t rsp);
    int n;
    n = 0;
    while (!wb_rsp.ack)
    begin
      @(posedge clk);
      #1;
      n++;
      if (n > 20)
        abort_run("no acknowledge from the DUT within 20 cycles");
    end
    rsp = wb_rsp;
    @(posedge clk);  // master takes ack at this edge
    #1;
    wb_req     = '0;
    wb_req.cyc = (idle_gap > 0);
    expect_ack_low();
    repeat (idle_gap)
    begin
      @(posedge clk);
      #1;
      expect_ack_low();
    end
    wb_req.cyc = 1'b0;
    @(posedge clk);  // stb low for a cycle at least
    #1;
  endtask

  task automatic write_csr(input csr_op_e op, input logic [11:0] addr, input logic [31:0] d,
                           input int idle_gap);
    wb_rsp_t rsp;
    bus_start(1'b1, op, addr, d);
    @(posedge clk);  // request sampled here
    #1;
    model_write(op, addr, d);
    bus_finish(idle_gap, rsp);
  endtask

  task automatic read_csr(input logic [11:0] addr, output wb_rsp_t rsp);
    bus_start(1'b0, CSR_OP_NONE, addr, 32'h0);
    bus_finish(0, rsp);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    wb_rsp_t     rsp;
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] exp_v;
    logic [11:0] a;
    csr_op_e     op;
    logic        sat;

    seed        = 32'h32c89311;
    rst_n       = 1'b0;
    wb_req      = '0;
    core_id     = '0;
    cluster_id  = '0;
    core_events = '0;
    ext_events  = '0;
    curr_pc_if  = '0;
    curr_pc_id  = '0;
    save_pc_if  = 1'b0;
    save_pc_id  = 1'b0;
    m_scratch   = '0;
    m_epc       = '0;
    m_pcer      = '0;
    m_pcmr      = PCMR_RESET;
    m_count_en  = 1'b0;
    m_stall_q   = 1'b0;
    for (int i = 0; i < N_PERF_COUNTERS; i++)
      m_cnt[i] = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    // constants, hart id, unmapped space
    r          = $random(seed);
    core_id    = r[4:0];
    cluster_id = r[9:5];
    read_csr(CSR_MCPUID, rsp);
    check_rsp(rsp, acked(MCPUID_VALUE), "mcpuid");
    read_csr(CSR_MIMPID, rsp);
    check_rsp(rsp, acked(MIMPID_VALUE), "mimpid");
    read_csr(CSR_MHARTID, rsp);
    check_rsp(rsp, acked({22'b0, cluster_id, core_id}), "mhartid");
    repeat (8)
    begin
      r = $random(seed);
      a = is_mapped(r[11:0]) ? 12'h123 : r[11:0];  // 123 is a hole
      read_csr(a, rsp);
      check_rsp(rsp, acked(32'h0), $sformatf("unmapped %h", a));
    end

    // mscratch write, set, clear
    repeat (200)
    begin
      r  = $random(seed);
      d  = $random(seed);
      op = csr_op_e'(2'd1 + 2'(r % 3));
      write_csr(op, CSR_MSCRATCH, d, 0);
      read_csr(CSR_MSCRATCH, rsp);
      check_rsp(rsp, acked(m_scratch), "mscratch");
    end
    r = $random(seed);
    write_csr(CSR_OP_WRITE, {2'b11, r[9:0]}, $random(seed), 0);  // must be dropped
    read_csr(CSR_MCPUID, rsp);
    check_rsp(rsp, acked(MCPUID_VALUE), "mcpuid");

    // exception pc, first pass has both saves up
    for (int n = 0; n < 40; n++)
    begin
      r = $random(seed);
      if (n == 0)
        r[1:0] = 2'b11;
      curr_pc_if = $random(seed);
      curr_pc_id = $random(seed);
      save_pc_if = r[0];
      save_pc_id = r[1];
      exp_v      = r[0] ? curr_pc_if : (r[1] ? curr_pc_id : m_epc);
      @(posedge clk);
      #1;
      save_pc_if = 1'b0;
      save_pc_id = 1'b0;
      m_epc      = exp_v;
      check_data(epcr, m_epc, "epcr_o");
      if (r[2])
      begin
        read_csr(CSR_MEPC, rsp);
        check_rsp(rsp, acked(m_epc), "mepc");
      end
    end
    curr_pc_if = $random(seed);
    bus_start(1'b1, CSR_OP_WRITE, CSR_MEPC, $random(seed));
    save_pc_if = 1'b1;  // same edge as the bus write
    @(posedge clk);
    #1;
    save_pc_if = 1'b0;
    m_epc      = curr_pc_if;
    bus_finish(0, rsp);
    check_data(epcr, m_epc, "epcr_o");
    read_csr(CSR_MEPC, rsp);
    check_rsp(rsp, acked(m_epc), "mepc");

    ////////////////////////////////////////////////////////////
    // event counting
    ////////////////////////////////////////////////////////////

    m_count_en = 1'b1;
    write_csr(CSR_OP_WRITE, CSR_PCER, $random(seed), 0);
    write_csr(CSR_OP_SET, CSR_PCMR, 32'h1, 0);
    repeat (100)
    begin
      r                = $random(seed);
      core_events      = r[8:0];
      core_events.rsvd = 1'b0;
      ext_events       = r[N_CORE_EVENTS +: N_EXT_EVENTS];
      @(posedge clk);
      #1;
    end
    core_events = '0;
    ext_events  = '0;
    write_csr(CSR_OP_WRITE, CSR_PCER, 32'h0, 0);
    repeat (3) @(posedge clk);
    #1;
    m_count_en = 1'b0;
    for (int i = 1; i < N_PERF_COUNTERS; i++)  // cycle counter skipped
    begin
      read_csr(12'(CSR_PCCR_BASE + i), rsp);
      check_rsp(rsp, acked(m_cnt[i]), $sformatf("pccr[%0d]", i));
    end

    // saturate then wrap on the load counter
    for (int p = 0; p < 2; p++)
    begin
      sat = (p == 0);
      write_csr(CSR_OP_WRITE, CSR_PCMR, {30'b0, sat, 1'b1}, 0);
      write_csr(CSR_OP_WRITE, CSR_PCCR_ALL, 32'hFFFF_FFFD, 0);
      write_csr(CSR_OP_WRITE, CSR_PCER, 32'(1) << EV_LOAD, 0);
      core_events.mem_load = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      core_events.mem_load = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      exp_v = 32'hFFFF_FFFD;
      repeat (4)
        if (!(sat && (exp_v == 32'hFFFF_FFFF)))
          exp_v = exp_v + 32'd1;
      read_csr(12'(CSR_PCCR_BASE + EV_LOAD), rsp);
      check_rsp(rsp, acked(exp_v), sat ? "pccr load sat" : "pccr load wrap");
      write_csr(CSR_OP_WRITE, CSR_PCER, 32'h0, 0);
    end
    write_csr(CSR_OP_WRITE, CSR_PCMR, 32'(PCMR_RESET), 0);

    // cyc held through idle gaps, one access each
    write_csr(CSR_OP_WRITE, CSR_MSCRATCH, 32'h0, 0);
    for (int g = 2; g < 6; g++)
    begin
      write_csr(CSR_OP_SET, CSR_MSCRATCH, $random(seed), g);
      read_csr(CSR_MSCRATCH, rsp);
      check_rsp(rsp, acked(m_scratch), "mscratch");
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/csr_assertions.sv ====
// bus handshake and exception pc checks; bound twice with the inputs a target lacks tied low
`timescale 1ns/1ns
`default_nettype none

module csr_assertions
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        ack_i,
  input  logic        save_pc_if_i,
  input  logic [31:0] curr_pc_if_i,
  input  logic [31:0] epcr_i
);

  ////////////////////////////////////////////////////////////
  // wishbone handshake
  ////////////////////////////////////////////////////////////

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    ack_i |-> (cyc_i && stb_i))
    else $error("ack seen without cyc and stb");

  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    ack_i |=> !ack_i)
    else $error("ack high two cycles in a row");

  // first edge after reset release
  a_ack_reset: assert property (@(posedge clk) $rose(rst_n) |-> !ack_i)
    else $error("ack high right after reset");

  ////////////////////////////////////////////////////////////
  // exception pc
  ////////////////////////////////////////////////////////////

  a_epc_save: assert property (@(posedge clk) disable iff (!rst_n)
    save_pc_if_i |=> (epcr_i == $past(curr_pc_if_i)))
    else $error("epcr_o does not hold the saved IF pc");

endmodule

bind csr_wb_adapter csr_assertions csr_wb_assertions_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .cyc_i        (wb_req_i.cyc),
  .stb_i        (wb_req_i.stb),
  .ack_i        (wb_rsp_o.ack),
  .save_pc_if_i (1'b0),
  .curr_pc_if_i (32'b0),
  .epcr_i       (32'b0)
);

bind cs_registers csr_assertions csr_epc_assertions_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .cyc_i        (1'b0),
  .stb_i        (1'b0),
  .ack_i        (1'b0),
  .save_pc_if_i (save_pc_if_i),
  .curr_pc_if_i (curr_pc_if_i),
  .epcr_i       (epcr_o)
);

`default_nettype wire

// ==== hdl/csr_subsystem_top.sv ====
// CSR subsystem top; wishbone access takes two cycles, exception pc inputs go straight to the CSR file
`timescale 1ns/1ns
`default_nettype none

module csr_subsystem_top import csr_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,

  input  wb_req_t                 wb_req_i,
  output wb_rsp_t                 wb_rsp_o,

  input  logic [4:0]              core_id_i,
  input  logic [4:0]              cluster_id_i,

  input  core_events_t            core_events_i,
  input  logic [N_EXT_EVENTS-1:0] ext_events_i,

  input  logic [31:0]             curr_pc_if_i,
  input  logic [31:0]             curr_pc_id_i,
  input  logic                    save_pc_if_i,
  input  logic                    save_pc_id_i,
  output logic [31:0]             epcr_o
);

  csr_req_t     csr_req;
  logic         csr_req_valid;
  logic [31:0]  csr_rdata;
  perf_events_t perf_events;

  // bus to register request
  csr_wb_adapter csr_wb_adapter_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .wb_req_i        (wb_req_i),
    .wb_rsp_o        (wb_rsp_o),
    .csr_req_o       (csr_req),
    .csr_req_valid_o (csr_req_valid),
    .csr_rdata_i     (csr_rdata)
  );

  // core events to counter inputs
  perf_event_sampler perf_event_sampler_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .core_events_i (core_events_i),
    .ext_events_i  (ext_events_i),
    .perf_events_o (perf_events)
  );

  cs_registers cs_registers_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .core_id_i       (core_id_i),
    .cluster_id_i    (cluster_id_i),
    .csr_req_i       (csr_req),
    .csr_req_valid_i (csr_req_valid),
    .csr_rdata_o     (csr_rdata),
    .perf_events_i   (perf_events),
    .curr_pc_if_i    (curr_pc_if_i),
    .curr_pc_id_i    (curr_pc_id_i),
    .save_pc_if_i    (save_pc_if_i),
    .save_pc_id_i    (save_pc_id_i),
    .epcr_o          (epcr_o)
  );

endmodule

`default_nettype wire

// ==== hdl/cs_registers.sv ====
// machine CSR file; no privilege checks or traps, unmapped reads give zero, 11:10 == 11 read-only
`timescale 1ns/1ns
`default_nettype none

module cs_registers import csr_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  input  logic [4:0]  core_id_i,
  input  logic [4:0]  cluster_id_i,

  // access port answered comb
  input  csr_req_t    csr_req_i,
  input  logic        csr_req_valid_i,
  output logic [31:0] csr_rdata_o,

  input  perf_events_t perf_events_i,

  // exception controller
  input  logic [31:0] curr_pc_if_i,
  input  logic [31:0] curr_pc_id_i,
  input  logic        save_pc_if_i,
  input  logic        save_pc_id_i,
  output logic [31:0] epcr_o
);

  csr_op_e     op;  // effective op after valid and read-only gating
  logic        is_readonly;

  logic        is_constant;
  logic        is_register;
  logic [31:0] constant_rdata;
  logic [31:0] register_rdata;
  logic [31:0] perf_rdata;

  logic [31:0] mscratch_q;
  logic [31:0] mepc_q;

  // perf counter state
  logic [N_PERF_COUNTERS-1:0]        pcer_q, pcer_n;
  logic [1:0]                        pcmr_q, pcmr_n;
  logic [N_PERF_COUNTERS-1:0][31:0]  pccr_q, pccr_n;
  perf_events_t                      pccr_inc, pccr_inc_q;
  logic [31:0]                       pcer_wide, pcmr_wide;

  logic        is_pcer;
  logic        is_pcmr;
  logic        is_pccr;
  logic        pccr_all_sel;
  logic [4:0]  pccr_index;

  // write, set or clear on a 32-bit value
  function automatic logic [31:0] apply_op(input csr_op_e    fop,
                                           input logic [31:0] old_v,
                                           input logic [31:0] wdata);
    logic [31:0] res;
    res = old_v;
    case (fop)
      CSR_OP_WRITE: res = wdata;
      CSR_OP_SET:   res = old_v | wdata;
      CSR_OP_CLEAR: res = old_v & ~wdata;
      default:      res = old_v;
    endcase
    return res;
  endfunction

  assign is_readonly = (csr_req_i.addr[11:10] == 2'b11);
  assign op = (csr_req_valid_i && !is_readonly) ? csr_req_i.op : CSR_OP_NONE;

  ////////////////////////////////////////////////////////////
  // decoders and read mux
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    is_constant    = 1'b1;
    constant_rdata = '0;
    case (csr_req_i.addr)
      CSR_MCPUID:  constant_rdata = MCPUID_VALUE;
      CSR_MIMPID:  constant_rdata = MIMPID_VALUE;
      CSR_MHARTID: constant_rdata = {22'b0, cluster_id_i, core_id_i};
      default:     is_constant = 1'b0;
    endcase
  end

  always_comb
  begin
    is_register    = 1'b1;
    register_rdata = '0;
    case (csr_req_i.addr)
      CSR_MSCRATCH: register_rdata = mscratch_q;
      CSR_MEPC:     register_rdata = mepc_q;
      default:      is_register = 1'b0;
    endcase
  end

  always_comb
  begin
    is_pcer      = (csr_req_i.addr == CSR_PCER);
    is_pcmr      = (csr_req_i.addr == CSR_PCMR);
    is_pccr      = (csr_req_i.addr[11:5] == CSR_PCCR_BASE[11:5]);  // 780..79F
    pccr_all_sel = (csr_req_i.addr == CSR_PCCR_ALL);
    pccr_index   = csr_req_i.addr[4:0];
    perf_rdata   = '0;

    if (is_pcer)
      perf_rdata[N_PERF_COUNTERS-1:0] = pcer_q;
    else if (is_pcmr)
      perf_rdata[1:0] = pcmr_q;
    else if (is_pccr && !pccr_all_sel && (pccr_index < N_PERF_COUNTERS))
      perf_rdata = pccr_q[pccr_index];  // slots past the bank read zero
  end

  // perf decode already yields zero for anything unmapped
  assign csr_rdata_o = is_constant ? constant_rdata :
                       is_register ? register_rdata : perf_rdata;

  ////////////////////////////////////////////////////////////
  // scratch and exception pc
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      mscratch_q <= '0;
      mepc_q     <= '0;
    end
    else
    begin
      if (csr_req_i.addr == CSR_MSCRATCH)
        mscratch_q <= apply_op(op, mscratch_q, csr_req_i.wdata);

      // exception save beats the bus and IF beats ID
      if (save_pc_if_i)
        mepc_q <= curr_pc_if_i;
      else if (save_pc_id_i)
        mepc_q <= curr_pc_id_i;
      else if (csr_req_i.addr == CSR_MEPC)
        mepc_q <= apply_op(op, mepc_q, csr_req_i.wdata);
    end
  end

  assign epcr_o = mepc_q;

  ////////////////////////////////////////////////////////////
  // performance counters
  ////////////////////////////////////////////////////////////

  assign pccr_inc = perf_events_i & pcer_q & {N_PERF_COUNTERS{pcmr_q[0]}};

  always_comb
  begin
    for (int i = 0; i < N_PERF_COUNTERS; i++)
    begin
      pccr_n[i] = pccr_q[i];
      // apply last cycle's decision and hold at all ones when saturating
      if (pccr_inc_q[i] && ((pccr_q[i] != 32'hFFFF_FFFF) || !pcmr_q[1]))
        pccr_n[i] = pccr_q[i] + 32'd1;
      // bus write overrides the increment
      if (is_pccr && (op != CSR_OP_NONE) && (pccr_all_sel || (pccr_index == 5'(i))))
        pccr_n[i] = apply_op(op, pccr_q[i], csr_req_i.wdata);
    end
  end

  assign pcer_wide = apply_op(op, {{(32-N_PERF_COUNTERS){1'b0}}, pcer_q}, csr_req_i.wdata);
  assign pcmr_wide = apply_op(op, {30'b0, pcmr_q}, csr_req_i.wdata);

  assign pcer_n = is_pcer ? pcer_wide[N_PERF_COUNTERS-1:0] : pcer_q;
  assign pcmr_n = is_pcmr ? pcmr_wide[1:0] : pcmr_q;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      pcer_q     <= '0;
      pcmr_q     <= PCMR_RESET;  // enabled and saturating
      pccr_q     <= '0;
      pccr_inc_q <= '0;
    end
    else
    begin
      pcer_q     <= pcer_n;
      pcmr_q     <= pcmr_n;
      pccr_q     <= pccr_n;
      pccr_inc_q <= pccr_inc;  // applied next cycle
    end
  end

endmodule

`default_nettype wire

// ==== hdl/perf_event_sampler.sv ====
// conditions raw core events for the counters; hazard and branch events lag stall_id by one register
`timescale 1ns/1ns
`default_nettype none

module perf_event_sampler import csr_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,

  input  core_events_t            core_events_i,
  input  logic [N_EXT_EVENTS-1:0] ext_events_i,

  output perf_events_t            perf_events_o
);

  logic stall_id_q;  // decode stall from last cycle

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      stall_id_q <= 1'b0;
    end
    else
    begin
      stall_id_q <= core_events_i.stall_id;
    end
  end

  ////////////////////////////////////////////////////////////
  // event qualification
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    perf_events_o = '0;

    perf_events_o[EV_CYCLES]   = 1'b1;                      // every cycle
    perf_events_o[EV_INSTR]    = ~core_events_i.stall_id;   // retired-ish
    perf_events_o[EV_LD_STALL] = core_events_i.ld_stall & ~stall_id_q;
    perf_events_o[EV_JR_STALL] = core_events_i.jr_stall & ~stall_id_q;
    perf_events_o[EV_IMISS]    = core_events_i.instr_fetch;
    perf_events_o[EV_LOAD]     = core_events_i.mem_load;
    perf_events_o[EV_STORE]    = core_events_i.mem_store;
    perf_events_o[EV_JUMP]     = core_events_i.jump & ~stall_id_q;   // count once per jump
    perf_events_o[EV_BRANCH]   = core_events_i.branch & ~stall_id_q;

    // external events straight through
    for (int i = 0; i < N_EXT_EVENTS; i++)
    begin
      perf_events_o[EV_EXT_BASE + i] = ext_events_i[i];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/csr_wb_adapter.sv ====
// wishbone classic slave; master must drop stb for a cycle after ack and gets one access per cycle
`timescale 1ns/1ns
`default_nettype none

module csr_wb_adapter import csr_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // wishbone side
  input  wb_req_t     wb_req_i,
  output wb_rsp_t     wb_rsp_o,

  // register file side
  output csr_req_t    csr_req_o,
  output logic        csr_req_valid_o,
  input  logic [31:0] csr_rdata_i
);

  logic        ack_q;    // doubles as pending-ack flag
  logic [31:0] rdata_q;  // read data held for the ack cycle
  logic        req_fire;
  csr_op_e     bus_op;

  ////////////////////////////////////////////////////////////
  // request decode
  ////////////////////////////////////////////////////////////

  // new access only when ack is not already on its way
  assign req_fire = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

  // op lives in the high address bits and matters only on writes
  always_comb
  begin
    if (wb_req_i.we)
      bus_op = csr_op_e'(wb_req_i.adr[WB_OP_MSB:WB_OP_LSB]);
    else
      bus_op = CSR_OP_NONE;  // plain read
  end

  assign csr_req_o.addr    = wb_req_i.adr[CSR_ADDR_W-1:0];
  assign csr_req_o.wdata   = wb_req_i.dat;
  assign csr_req_o.op      = bus_op;
  assign csr_req_valid_o   = req_fire;  // one cycle wide

  ////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= req_fire;  // ack one cycle after sample
    end
  end

  // read data captured with the request
  always_ff @(posedge clk)
  begin
    if (req_fire)
    begin
      rdata_q <= csr_rdata_i;  // rdata is comb in same cycle
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/csr_pkg.sv ====
// shared CSR types and constants; bus ops ride in adr[13:12] on writes, reads always carry op none
`default_nettype none

package csr_pkg;

  ////////////////////////////////////////////////////////////
  // widths and counts
  ////////////////////////////////////////////////////////////

  localparam int CSR_ADDR_W      = 12;
  localparam int WB_ADDR_W       = 14;  // csr addr plus op field
  localparam int WB_OP_LSB       = 12;  // adr[13:12] = op on writes
  localparam int WB_OP_MSB       = 13;

  localparam int N_CORE_EVENTS   = 9;
  localparam int N_EXT_EVENTS    = 2;
  localparam int N_PERF_COUNTERS = N_CORE_EVENTS + N_EXT_EVENTS;

  // counter slots, cycle counter first
  localparam int EV_CYCLES       = 0;
  localparam int EV_INSTR        = 1;
  localparam int EV_LD_STALL     = 2;
  localparam int EV_JR_STALL     = 3;
  localparam int EV_IMISS        = 4;  // cycles waiting on fetch
  localparam int EV_LOAD         = 5;
  localparam int EV_STORE        = 6;
  localparam int EV_JUMP         = 7;
  localparam int EV_BRANCH       = 8;
  localparam int EV_EXT_BASE     = N_CORE_EVENTS;

  ////////////////////////////////////////////////////////////
  // csr addresses and values
  ////////////////////////////////////////////////////////////

  localparam logic [CSR_ADDR_W-1:0] CSR_MCPUID    = 12'hF00;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIMPID    = 12'hF01;
  localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID   = 12'hF10;
  localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH  = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC      = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_PCER      = 12'h7A0;
  localparam logic [CSR_ADDR_W-1:0] CSR_PCMR      = 12'h7A1;
  localparam logic [CSR_ADDR_W-1:0] CSR_PCCR_BASE = 12'h780;  // 780..79F window
  localparam logic [CSR_ADDR_W-1:0] CSR_PCCR_ALL  = 12'h79F;  // hits every counter

  localparam logic [31:0] MCPUID_VALUE = 32'h0000_0100;  // RV32I
  localparam logic [31:0] MIMPID_VALUE = 32'h0000_8000;

  localparam logic [1:0]  PCMR_RESET   = 2'b11;  // bit0 global enable, bit1 saturate

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef struct packed {
    logic [CSR_ADDR_W-1:0] addr;
    logic [31:0]           wdata;
    csr_op_e               op;
  } csr_req_t;  // 46 bits

  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [WB_ADDR_W-1:0] adr;
    logic [31:0]          dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;  // 33 bits

  typedef struct packed {
    logic stall_id;
    logic instr_fetch;
    logic jump;
    logic branch;
    logic ld_stall;
    logic jr_stall;
    logic mem_load;
    logic mem_store;
    logic rsvd;  // pad, tie to zero
  } core_events_t;

  typedef logic [N_PERF_COUNTERS-1:0] perf_events_t;

endpackage

`default_nettype wire
